//--- design/radio_core.sv
// Radio control top level joining the command processor, timekeeper and setting registers
`timescale 1ns/1ps

module radio_core
   import radio_pkg::*;
#(
   parameter int MISC_WIDTH = MISC_W_DEF
)
(
   input  logic                  radio_clk,
   input  logic                  i_rst,
   // Control in
   input  axis_beat_t            i_ctrl,
   input  logic                  i_ctrl_valid,
   output logic                  o_ctrl_ready,
   // Response out
   output axis_beat_t            o_resp,
   output logic                  o_resp_valid,
   input  logic                  i_resp_ready,
   // Radio side
   input  logic [31:0]           i_rx,
   input  logic                  i_pps,
   output logic [MISC_WIDTH-1:0] o_misc_outs,
   output logic                  o_sync_dacs
);

   set_bus_t    set_bus;            // Shared settings bus
   logic [63:0] vita_time;
   logic [63:0] vita_time_lastpps;  // Time at last PPS edge
   logic [63:0] readback;

   //////////////////////////////
   // Command processor
   //////////////////////////////
   radio_ctrl_proc u_radio_ctrl_proc (
      .radio_clk    (radio_clk),
      .i_rst        (i_rst),
      .i_ctrl       (i_ctrl),
      .i_ctrl_valid (i_ctrl_valid),
      .o_ctrl_ready (o_ctrl_ready),
      .o_resp       (o_resp),
      .o_resp_valid (o_resp_valid),
      .i_resp_ready (i_resp_ready),
      .i_readback   (readback),
      .o_set        (set_bus)
   );

   radio_timekeeper u_radio_timekeeper (
      .radio_clk           (radio_clk),
      .i_rst               (i_rst),
      .i_set               (set_bus),
      .i_pps               (i_pps),
      .o_vita_time         (vita_time),
      .o_vita_time_lastpps (vita_time_lastpps)
   );

   // Settings and readback
   radio_settings #(
      .MISC_WIDTH (MISC_WIDTH)
   ) u_radio_settings (
      .radio_clk           (radio_clk),
      .i_rst               (i_rst),
      .i_set               (set_bus),
      .i_vita_time         (vita_time),
      .i_vita_time_lastpps (vita_time_lastpps),
      .i_rx                (i_rx),
      .o_readback          (readback),
      .o_misc_outs         (o_misc_outs),
      .o_sync_dacs         (o_sync_dacs)
   );

endmodule

//--- design/radio_ctrl_proc.sv
// Control packet processor that turns commands into settings strobes and readback responses
`timescale 1ns/1ps

module radio_ctrl_proc
   import radio_pkg::*;
(
   input  logic        radio_clk,
   input  logic        i_rst,
   input  axis_beat_t  i_ctrl,
   input  logic        i_ctrl_valid,
   output logic        o_ctrl_ready,
   output axis_beat_t  o_resp,
   output logic        o_resp_valid,
   input  logic        i_resp_ready,
   input  logic [63:0] i_readback,
   output set_bus_t    o_set
);

   ctrl_state_e      state;
   ctrl_hdr_t        hdr;       // Header view of the input beat
   ctrl_cmd_t        cmd;       // Command view of the input beat
   logic             ctrl_xfer;
   logic             resp_xfer;
   logic [SEQ_W-1:0] seqnum_q;  // Echoed in response
   logic [7:0]       addr_q;
   logic [31:0]      data_q;
   logic [63:0]      rb_q;      // Latched readback word

   assign hdr       = ctrl_hdr_t'(i_ctrl.data);
   assign cmd       = ctrl_cmd_t'(i_ctrl.data);
   assign ctrl_xfer = i_ctrl_valid & o_ctrl_ready;
   assign resp_xfer = o_resp_valid & i_resp_ready;

   //////////////////////////////
   // FSM
   //////////////////////////////
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         state <= ST_HDR;
      end else begin
         case (state)
            ST_HDR: begin
               // Header with last set is a lone beat and is dropped
               if (ctrl_xfer && !i_ctrl.last) begin
                  state <= ST_CMD;
               end
            end
            ST_CMD: begin
               if (ctrl_xfer) begin
                  state <= i_ctrl.last ? ST_STROBE : ST_DRAIN;  // Long packet drains the rest
               end
            end
            ST_DRAIN: begin
               if (ctrl_xfer && i_ctrl.last) begin
                  state <= ST_STROBE;
               end
            end
            ST_STROBE:   state <= ST_LATCH;     // Setting lands on this edge
            ST_LATCH:    state <= ST_RESP_HDR;  // Readback now reflects the write
            ST_RESP_HDR: begin
               if (resp_xfer) begin
                  state <= ST_RESP_DATA;
               end
            end
            ST_RESP_DATA: begin
               if (resp_xfer) begin
                  state <= ST_HDR;
               end
            end
            default: state <= ST_HDR;
         endcase
      end
   end

   // Packet fields and readback
   always_ff @(posedge radio_clk) begin
      if (state == ST_HDR && ctrl_xfer) begin
         seqnum_q <= hdr.seqnum;
      end
      if (state == ST_CMD && ctrl_xfer) begin
         addr_q <= cmd.addr;
         data_q <= cmd.data;
      end
      if (state == ST_LATCH) begin
         rb_q <= i_readback;
      end
   end

   //////////////////////////////
   // Outputs
   //////////////////////////////
   // Input closed from the settings strobe until the response is gone
   assign o_ctrl_ready = (state == ST_HDR) || (state == ST_CMD) || (state == ST_DRAIN);

   assign o_set.stb  = (state == ST_STROBE);  // Single cycle
   assign o_set.addr = addr_q;
   assign o_set.data = data_q;

   assign o_resp_valid = (state == ST_RESP_HDR) || (state == ST_RESP_DATA);
   assign o_resp.last  = (state == ST_RESP_DATA);
   // Seqnum at 59:48 and addr at 39:32
   assign o_resp.data  = (state == ST_RESP_DATA) ? rb_q
                                                 : {4'd0, seqnum_q, 8'd0, addr_q, 32'd0};

endmodule

//--- design/radio_pkg.sv
// Radio control package with the settings map, stream beat and command packet layouts
package radio_pkg;

   //////////////////////////////
   // Widths
   //////////////////////////////
   localparam int DATA_W     = 64;  // Stream beat
   localparam int SEQ_W      = 12;  // Packet sequence number
   localparam int MISC_W_DEF = 8;   // Default misc output width

   //////////////////////////////
   // Settings bus addresses
   //////////////////////////////
   localparam logic [7:0] SR_DACSYNC   = 8'd5;    // Any write pulses DAC sync
   localparam logic [7:0] SR_TEST      = 8'd7;    // Test word for readback
   localparam logic [7:0] SR_MISC_OUTS = 8'd24;
   localparam logic [7:0] SR_READBACK  = 8'd32;   // Readback mux select
   localparam logic [7:0] SR_TIME_HI   = 8'd128;  // Held until the low word arrives
   localparam logic [7:0] SR_TIME_LO   = 8'd129;  // Loads the whole 64-bit time

   // One beat of the control or response stream
   typedef struct packed {
      logic              last;
      logic [DATA_W-1:0] data;
   } axis_beat_t;

   // First beat of a command packet
   typedef struct packed {
      logic [3:0]       pad_hi;
      logic [SEQ_W-1:0] seqnum;
      logic [47:0]      pad_lo;
   } ctrl_hdr_t;

   // Second beat with the settings write
   typedef struct packed {
      logic [23:0] pad;
      logic [7:0]  addr;
      logic [31:0] data;
   } ctrl_cmd_t;

   // Settings bus where the strobe qualifies addr and data
   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   // Readback select where codes 5 to 7 read zero
   typedef enum logic [2:0] {
      RB_NONE     = 3'd0,
      RB_TIME     = 3'd1,
      RB_TIME_PPS = 3'd2,
      RB_RX_TEST  = 3'd3,
      RB_MISC     = 3'd4
   } rb_sel_e;

   // Command processor FSM
   typedef enum logic [2:0] {
      ST_HDR,        // Wait for header beat
      ST_CMD,        // Wait for command beat
      ST_DRAIN,      // Toss extra beats up to last
      ST_STROBE,     // Settings strobe
      ST_LATCH,      // Grab readback
      ST_RESP_HDR,   // Response beat 0
      ST_RESP_DATA   // Response beat 1
   } ctrl_state_e;

endpackage

//--- design/radio_settings.sv
// Radio setting registers with DAC sync pulse, misc outputs and the readback mux
`timescale 1ns/1ps

module radio_settings
   import radio_pkg::*;
#(
   parameter int MISC_WIDTH = MISC_W_DEF
)
(
   input  logic                  radio_clk,
   input  logic                  i_rst,
   input  set_bus_t              i_set,
   input  logic [63:0]           i_vita_time,
   input  logic [63:0]           i_vita_time_lastpps,
   input  logic [31:0]           i_rx,
   output logic [63:0]           o_readback,
   output logic [MISC_WIDTH-1:0] o_misc_outs,
   output logic                  o_sync_dacs
);

   logic [31:0] test_q;   // Test word
   rb_sel_e     rb_sel_q;
   logic        wr_dacsync;
   logic        wr_test;
   logic        wr_misc;
   logic        wr_rb;

   // Address decode
   assign wr_dacsync = i_set.stb && (i_set.addr == SR_DACSYNC);
   assign wr_test    = i_set.stb && (i_set.addr == SR_TEST);
   assign wr_misc    = i_set.stb && (i_set.addr == SR_MISC_OUTS);
   assign wr_rb      = i_set.stb && (i_set.addr == SR_READBACK);

   //////////////////////////////
   // Registers
   //////////////////////////////
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         test_q      <= '0;
         o_misc_outs <= '0;
         rb_sel_q    <= RB_NONE;
         o_sync_dacs <= 1'b0;
      end else begin
         o_sync_dacs <= wr_dacsync;  // One cycle per write, data ignored
         if (wr_test) begin
            test_q <= i_set.data;
         end
         if (wr_misc) begin
            o_misc_outs <= i_set.data[MISC_WIDTH-1:0];
         end
         if (wr_rb) begin
            rb_sel_q <= rb_sel_e'(i_set.data[2:0]);  // Undefined codes kept, read zero
         end
      end
   end

   //////////////////////////////
   // Readback mux
   //////////////////////////////
   always_comb begin
      case (rb_sel_q)
         RB_TIME:     o_readback = i_vita_time;
         RB_TIME_PPS: o_readback = i_vita_time_lastpps;
         RB_RX_TEST:  o_readback = {i_rx, test_q};
         RB_MISC:     o_readback = 64'(o_misc_outs);  // Zero extended
         default:     o_readback = '0;                // RB_NONE and 5..7
      endcase
   end

endmodule

//--- design/radio_timekeeper.sv
// Timekeeper with a loadable 64-bit time counter and PPS edge capture
`timescale 1ns/1ps

module radio_timekeeper
   import radio_pkg::*;
(
   input  logic        radio_clk,
   input  logic        i_rst,
   input  set_bus_t    i_set,
   input  logic        i_pps,
   output logic [63:0] o_vita_time,
   output logic [63:0] o_vita_time_lastpps
);

   logic [31:0] time_hi_q;   // Pending upper word
   logic        pps_q;       // Last cycle's PPS
   logic        pps_rise;
   logic        load_hi;
   logic        load_lo;

   assign load_hi  = i_set.stb && (i_set.addr == SR_TIME_HI);
   assign load_lo  = i_set.stb && (i_set.addr == SR_TIME_LO);
   assign pps_rise = i_pps & ~pps_q;  // Low to high

   //////////////////////////////
   // Time counter
   //////////////////////////////
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         time_hi_q   <= '0;
         o_vita_time <= '0;
      end else begin
         if (load_hi) begin
            time_hi_q <= i_set.data;  // Waits for the low word
         end
         if (load_lo) begin
            o_vita_time <= {time_hi_q, i_set.data};
         end else begin
            o_vita_time <= o_vita_time + 64'd1;
         end
      end
   end

   // PPS capture
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         pps_q               <= 1'b0;
         o_vita_time_lastpps <= '0;
      end else begin
         pps_q <= i_pps;
         if (pps_rise) begin
            o_vita_time_lastpps <= o_vita_time;
         end
      end
   end

endmodule

//--- dv/radio_checker.sv
// Response checker for the radio core that predicts responses from the command table
`timescale 1ns/1ps

module radio_checker
   import radio_pkg::*;
#(
   parameter int N_ENT      = 1,
   parameter int MISC_WIDTH = MISC_W_DEF
)
(
   input  logic                  radio_clk,
   input  logic                  i_rst,
   input  axis_beat_t            i_ctrl,
   input  logic                  i_ctrl_valid,
   input  logic                  i_ctrl_ready,
   input  axis_beat_t            i_resp,
   input  logic                  i_resp_valid,
   input  logic                  i_resp_ready,
   input  logic [MISC_WIDTH-1:0] i_misc_outs,
   input  logic                  i_sync_dacs,
   input  logic [SEQ_W-1:0]      i_tab_seq  [N_ENT],
   input  logic [7:0]            i_tab_addr [N_ENT],
   input  logic [31:0]           i_tab_data [N_ENT],
   input  logic                  i_tab_bad  [N_ENT],
   input  logic [63:0]           i_tab_rb   [N_ENT],
   input  logic [1:0]            i_tab_kind [N_ENT],
   output logic                  o_done,
   output int                    o_check_errors,
   output int                    o_proto_errors
);

   localparam logic [1:0] CK_EXACT = 2'd1;
   localparam logic [1:0] CK_TIME  = 2'd2;
   localparam logic [1:0] CK_PPS   = 2'd3;

   int                    exp_q [$];  // Table indices owed a response
   int                    pkt_idx;
   int                    n_good;
   int                    resp_cnt;
   int                    sync_seen;
   int                    sync_exp;
   logic                  in_data;    // Header beat already out
   logic                  rst_seen;
   logic                  held;       // Beat stalled last cycle
   axis_beat_t            held_beat;
   logic [MISC_WIDTH-1:0] misc_exp;
   logic [63:0]           last_time;  // Latest time read back

   task automatic flag_mismatch(input string what, input logic [63:0] got,
                                input logic [63:0] exp);
      $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
      o_check_errors++;
   endtask

   always @(posedge radio_clk) begin
      int          k;
      logic [63:0] hdr_exp;
      if (i_rst) begin
         exp_q.delete();
         pkt_idx        = 0;
         resp_cnt       = 0;
         sync_seen      = 0;
         sync_exp       = 0;
         n_good         = 0;
         in_data        = 1'b0;
         rst_seen       = 1'b0;
         held           = 1'b0;
         o_done         = 1'b0;
         misc_exp       = '0;
         last_time      = '0;
         o_check_errors = 0;
         o_proto_errors = 0;
         for (int j = 0; j < N_ENT; j++) begin
            if (!i_tab_bad[j]) n_good++;
         end
      end else begin
         if (!rst_seen) begin  // Values straight out of reset
            rst_seen = 1'b1;
            if ({i_ctrl_ready, i_resp_valid, i_sync_dacs} != 3'b100 || i_misc_outs != '0) begin
               flag_mismatch("outputs after reset",
                             64'({i_ctrl_ready, i_resp_valid, i_sync_dacs, i_misc_outs}),
                             64'({3'b100, {MISC_WIDTH{1'b0}}}));
            end
         end
         if (i_sync_dacs) sync_seen++;
         // End of a command packet
         if (i_ctrl_valid && i_ctrl_ready && i_ctrl.last) begin
            if (pkt_idx < N_ENT && !i_tab_bad[pkt_idx]) exp_q.push_back(pkt_idx);
            pkt_idx++;
         end
         if (held && (!i_resp_valid || i_resp != held_beat)) begin
            flag_mismatch("response beat changed while stalled", i_resp.data, held_beat.data);
         end
         held      = i_resp_valid && !i_resp_ready;
         held_beat = i_resp;
         //////////////////////////////
         // Response beats
         //////////////////////////////
         if (i_resp_valid && i_resp_ready) begin
            if (exp_q.size() == 0) begin
               o_proto_errors++;
               $display("Response beat at %0t arrived with no command outstanding", $time);
            end else if (!in_data) begin
               k       = exp_q[0];
               hdr_exp = (64'(i_tab_seq[k]) << 48) | (64'(i_tab_addr[k]) << 32);
               if (i_resp.last) flag_mismatch($sformatf("entry %0d header last", k), 64'd1, 64'd0);
               if (i_resp.data != hdr_exp) begin
                  flag_mismatch($sformatf("entry %0d header", k), i_resp.data, hdr_exp);
               end
               if (i_tab_addr[k] == SR_MISC_OUTS) misc_exp = i_tab_data[k][MISC_WIDTH-1:0];
               if (i_tab_addr[k] == SR_DACSYNC) sync_exp++;
               if (i_misc_outs != misc_exp) begin  // Settled well before the response
                  flag_mismatch("misc outputs", 64'(i_misc_outs), 64'(misc_exp));
               end
               in_data = 1'b1;
            end else begin
               k       = exp_q.pop_front();
               in_data = 1'b0;
               if (!i_resp.last) flag_mismatch($sformatf("entry %0d data last", k), 64'd0, 64'd1);
               case (i_tab_kind[k])
                  CK_EXACT: begin
                     if (i_resp.data != i_tab_rb[k]) begin
                        flag_mismatch($sformatf("entry %0d readback", k), i_resp.data,
                                      i_tab_rb[k]);
                     end
                  end
                  CK_TIME: begin
                     if (i_resp.data <= last_time) begin
                        flag_mismatch($sformatf("entry %0d time not past", k), i_resp.data,
                                      last_time);
                     end
                  end
                  CK_PPS: begin
                     if (i_resp.data == '0 || i_resp.data <= last_time) begin
                        flag_mismatch($sformatf("entry %0d PPS time", k), i_resp.data, last_time);
                     end
                  end
                  default: ;
               endcase
               if (i_tab_kind[k] == CK_TIME || i_tab_kind[k] == CK_PPS ||
                   i_tab_addr[k] == SR_TIME_LO) begin
                  last_time = i_resp.data;
               end
               resp_cnt++;
               if (resp_cnt == n_good) begin  // Last response so all sync pulses are in
                  if (sync_seen != sync_exp) begin
                     flag_mismatch("DAC sync pulse count", 64'(sync_seen), 64'(sync_exp));
                  end
                  o_done = 1'b1;
               end
            end
         end
      end
   end

endmodule

//--- dv/tb_radio.sv
// Testbench top for the radio control core with a command table, random back-pressure and timeout
`timescale 1ns/1ps

module tb_radio
   import radio_pkg::*;
();

   localparam int          MISC_W      = 6;   // Narrower than a settings word
   localparam int          N_ENT       = 22;
   localparam int          PPS_IDX     = 16;  // PPS pulse goes out before this entry
   localparam int          TIMEOUT_CYC = N_ENT * 40 + 100;
   localparam logic [31:0] RX_WORD     = 32'hA5C3_0F1E;
   localparam logic [1:0]  CK_NONE     = 2'd0;
   localparam logic [1:0]  CK_EXACT    = 2'd1;
   localparam logic [1:0]  CK_TIME     = 2'd2;  // Later than the last time read
   localparam logic [1:0]  CK_PPS      = 2'd3;  // Nonzero PPS time that is also later

   logic              radio_clk = 1'b0;
   logic              i_rst;
   axis_beat_t        i_ctrl;
   logic              i_ctrl_valid;
   logic              o_ctrl_ready;
   axis_beat_t        o_resp;
   logic              o_resp_valid;
   logic              i_resp_ready;
   logic [31:0]       i_rx;
   logic              i_pps;
   logic [MISC_W-1:0] o_misc_outs;
   logic              o_sync_dacs;
   int                cyc_cnt = 0;
   int                n_ent;
   logic              chk_done;
   int                check_errors;
   int                proto_errors;

   // Command table
   logic [SEQ_W-1:0] tab_seq  [N_ENT];
   logic [7:0]       tab_addr [N_ENT];
   logic [31:0]      tab_data [N_ENT];
   logic             tab_bad  [N_ENT];  // Header-only packet
   logic [63:0]      tab_rb   [N_ENT];  // Expected readback
   logic [1:0]       tab_kind [N_ENT];

   always #10 radio_clk = ~radio_clk;  // 20 ns period

   radio_core #(.MISC_WIDTH (MISC_W)) u_radio_core (
      .radio_clk    (radio_clk),
      .i_rst        (i_rst),
      .i_ctrl       (i_ctrl),
      .i_ctrl_valid (i_ctrl_valid),
      .o_ctrl_ready (o_ctrl_ready),
      .o_resp       (o_resp),
      .o_resp_valid (o_resp_valid),
      .i_resp_ready (i_resp_ready),
      .i_rx         (i_rx),
      .i_pps        (i_pps),
      .o_misc_outs  (o_misc_outs),
      .o_sync_dacs  (o_sync_dacs)
   );

   radio_checker #(.N_ENT (N_ENT), .MISC_WIDTH (MISC_W)) u_radio_checker (
      .radio_clk      (radio_clk),
      .i_rst          (i_rst),
      .i_ctrl         (i_ctrl),
      .i_ctrl_valid   (i_ctrl_valid),
      .i_ctrl_ready   (o_ctrl_ready),
      .i_resp         (o_resp),
      .i_resp_valid   (o_resp_valid),
      .i_resp_ready   (i_resp_ready),
      .i_misc_outs    (o_misc_outs),
      .i_sync_dacs    (o_sync_dacs),
      .i_tab_seq      (tab_seq),
      .i_tab_addr     (tab_addr),
      .i_tab_data     (tab_data),
      .i_tab_bad      (tab_bad),
      .i_tab_rb       (tab_rb),
      .i_tab_kind     (tab_kind),
      .o_done         (chk_done),
      .o_check_errors (check_errors),
      .o_proto_errors (proto_errors)
   );

   //////////////////////////////
   // Table
   //////////////////////////////
   // Misc register as seen on readback keeps the low MISC_W bits
   function automatic logic [63:0] misc_view(input logic [31:0] data);
      logic [63:0] mask;
      mask = (64'd1 << MISC_W) - 64'd1;
      return {32'd0, data} & mask;
   endfunction

   task automatic add_entry(input logic [7:0] addr, input logic [31:0] data, input logic bad,
                            input logic [63:0] rb, input logic [1:0] kind);
      tab_seq[n_ent]  = 12'hF80 + 12'(n_ent * 7);  // Wraps past FFF
      tab_addr[n_ent] = addr;
      tab_data[n_ent] = data;
      tab_bad[n_ent]  = bad;
      tab_rb[n_ent]   = rb;
      tab_kind[n_ent] = kind;
      n_ent++;
   endtask

   task automatic build_table();
      add_entry(SR_READBACK, 32'd0, 1'b0, 64'd0, CK_EXACT);  // RB_NONE
      add_entry(SR_TEST, 32'h1234_5678, 1'b0, 64'd0, CK_EXACT);
      add_entry(SR_READBACK, 32'd3, 1'b0, {RX_WORD, 32'h1234_5678}, CK_EXACT);
      add_entry(SR_TEST, 32'hDEAD_BEEF, 1'b0, {RX_WORD, 32'hDEAD_BEEF}, CK_EXACT);
      add_entry(8'd0, 32'd0, 1'b1, 64'd0, CK_NONE);
      add_entry(SR_MISC_OUTS, 32'hFFFF_FF9B, 1'b0, {RX_WORD, 32'hDEAD_BEEF}, CK_EXACT);
      add_entry(SR_READBACK, 32'd4, 1'b0, misc_view(32'hFFFF_FF9B), CK_EXACT);
      add_entry(SR_DACSYNC, 32'd0, 1'b0, misc_view(32'hFFFF_FF9B), CK_EXACT);
      add_entry(SR_READBACK, 32'd5, 1'b0, 64'd0, CK_EXACT);  // Undefined selects
      add_entry(SR_READBACK, 32'd7, 1'b0, 64'd0, CK_EXACT);
      add_entry(SR_DACSYNC, 32'd1, 1'b0, 64'd0, CK_EXACT);
      add_entry(SR_READBACK, 32'd1, 1'b0, 64'd0, CK_NONE);  // Free-running time
      add_entry(SR_TIME_HI, 32'h0000_0042, 1'b0, 64'd0, CK_NONE);
      add_entry(SR_TIME_LO, 32'h8000_0010, 1'b0, {32'h0000_0042, 32'h8000_0010}, CK_EXACT);
      add_entry(SR_TEST, 32'h0BAD_F00D, 1'b0, 64'd0, CK_TIME);
      add_entry(8'd0, 32'd0, 1'b1, 64'd0, CK_NONE);
      add_entry(SR_READBACK, 32'd2, 1'b0, 64'd0, CK_PPS);
      add_entry(SR_READBACK, 32'd1, 1'b0, 64'd0, CK_TIME);
      add_entry(SR_MISC_OUTS, 32'h0000_0025, 1'b0, 64'd0, CK_TIME);
      add_entry(SR_READBACK, 32'd4, 1'b0, misc_view(32'h0000_0025), CK_EXACT);
      add_entry(SR_DACSYNC, 32'd0, 1'b0, misc_view(32'h0000_0025), CK_EXACT);
      add_entry(8'd0, 32'd0, 1'b1, 64'd0, CK_NONE);  // Trailing lone header
   endtask

   //////////////////////////////
   // Stimulus
   //////////////////////////////
   // Starts on a falling edge and returns on the one after the transfer
   task automatic send_beat(input logic last, input logic [63:0] data);
      i_ctrl       = {last, data};
      i_ctrl_valid = 1'b1;
      while (!o_ctrl_ready) @(negedge radio_clk);
      @(negedge radio_clk);
      i_ctrl_valid = 1'b0;
   endtask

   task automatic send_packet(input int k);
      send_beat(tab_bad[k], {4'hC, tab_seq[k], 48'h1234_5678_9ABC});  // Junk in pad bits
      if (!tab_bad[k]) begin
         send_beat(1'b1, {24'h5A_5A5A, tab_addr[k], tab_data[k]});
      end
   endtask

   // Response back-pressure with ready low on about 30% of cycles
   task automatic drive_resp_ready();
      forever begin
         @(negedge radio_clk);
         i_resp_ready = ($urandom_range(99) >= 30);
      end
   endtask

   task automatic close_run(input logic timed_out);
      $display("Errors: %0d check, %0d protocol", check_errors, proto_errors);
      if (!timed_out && check_errors == 0 && proto_errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   endtask

   initial begin
      int gap;
      void'($urandom(32'h135c_0a67));
      i_rst        = 1'b1;
      i_ctrl       = '0;
      i_ctrl_valid = 1'b0;
      i_resp_ready = 1'b0;
      i_rx         = RX_WORD;
      i_pps        = 1'b0;
      n_ent        = 0;
      build_table();
      fork
         drive_resp_ready();
      join_none
      repeat (8) @(negedge radio_clk);
      i_rst = 1'b0;
      for (int k = 0; k < N_ENT; k++) begin
         gap = $urandom_range(4);
         repeat (gap) @(negedge radio_clk);
         if (k == PPS_IDX) begin
            while (!o_ctrl_ready) @(negedge radio_clk);  // Prior time read done
            i_pps = 1'b1;
            repeat (3) @(negedge radio_clk);
            i_pps = 1'b0;
         end
         send_packet(k);
      end
      while (!chk_done) @(negedge radio_clk);
      repeat (20) @(negedge radio_clk);  // Room for a stray beat
      close_run(1'b0);
   end

   // Run limit
   always @(posedge radio_clk) begin
      cyc_cnt <= cyc_cnt + 1;
      if (cyc_cnt == TIMEOUT_CYC) begin
         $display("Timeout: run still busy after %0d cycles", TIMEOUT_CYC);
         close_run(1'b1);
      end
   end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the radio control testbench with Verilator

ROOT_DIR="$(cd "$(dirname "$0")" && pwd)"
OBJ_DIR="obj_dir"
LOG_FILE="sim.log"

cd "$ROOT_DIR" || exit 1

echo "Building with Verilator"
verilator --binary --timing \
   --top-module tb_radio \
   -Mdir "$OBJ_DIR" -o sim_radio \
   -f tb.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

echo "Running simulation"
"./$OBJ_DIR/sim_radio" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -q "Test failed" "$LOG_FILE"; then
   echo "Failure reported in $LOG_FILE"
   exit 1
fi
echo "No failure reported in $LOG_FILE"
exit 0

//--- tb.f
design/radio_pkg.sv
design/radio_timekeeper.sv
design/radio_settings.sv
design/radio_ctrl_proc.sv
design/radio_core.sv
dv/radio_checker.sv
dv/tb_radio.sv
